/* hw/adc_cap_pkg.sv */
// ******************************
// shared register map, bus widths and register-bus states for the capture path
// compiled first, referenced by package scope from the RTL
// ******************************

package adc_cap_pkg;

  // bus and counter widths that carry a meaning
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [15:0] frame_len_t;
  typedef logic [31:0] frame_cnt_t;

  // ******************************
  // register map
  // ******************************

  // bit 0 enable, bit 1 offset-binary input format
  localparam reg_addr_t ADDR_CTRL      = 4'h0;
  localparam reg_addr_t ADDR_FRAME_LEN = 4'h4;
  // bit 0 is sticky overflow, write 1 to clear
  localparam reg_addr_t ADDR_STATUS    = 4'h8;
  localparam reg_addr_t ADDR_FRAME_CNT = 4'hC;

  // samples per frame out of reset
  localparam frame_len_t FRAME_LEN_RST = 16'd16;

  // write response and read data sequencing of the register slave
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_WRESP,
    BUS_RDATA
  } bus_state_e;

endpackage

/* hw/adc_cap_regs.sv */
// ******************************
// AXI4-Lite slave with the control, frame length, status and frame count
// registers of the capture path
// ******************************

module adc_cap_regs (
  input  logic                    clk,
  input  logic                    rst,

  // AXI4-Lite slave
  input  logic                    s_axil_awvalid,
  output logic                    s_axil_awready,
  input  adc_cap_pkg::reg_addr_t  s_axil_awaddr,
  input  logic                    s_axil_wvalid,
  output logic                    s_axil_wready,
  input  adc_cap_pkg::reg_data_t  s_axil_wdata,
  input  logic [3:0]              s_axil_wstrb,
  output logic                    s_axil_bvalid,
  input  logic                    s_axil_bready,
  output logic [1:0]              s_axil_bresp,
  input  logic                    s_axil_arvalid,
  output logic                    s_axil_arready,
  input  adc_cap_pkg::reg_addr_t  s_axil_araddr,
  output logic                    s_axil_rvalid,
  input  logic                    s_axil_rready,
  output adc_cap_pkg::reg_data_t  s_axil_rdata,
  output logic [1:0]              s_axil_rresp,

  // control towards the frame generator
  output logic                    enable,
  output logic                    format,
  output adc_cap_pkg::frame_len_t frame_len,

  // status from the datapath
  input  adc_cap_pkg::frame_cnt_t frame_cnt,
  input  logic                    overflow
);

  adc_cap_pkg::bus_state_e state;
  adc_cap_pkg::reg_data_t  rd_mux;
  logic                    write_fire;
  logic                    read_fire;
  logic                    status_clr;
  logic                    overflow_sticky;

  // ******************************
  // handshake
  // ******************************

  // a write needs address and data together, and it goes ahead of a read
  // that shows up on the same cycle
  assign write_fire = (state == adc_cap_pkg::BUS_IDLE) && s_axil_awvalid && s_axil_wvalid;
  assign read_fire  = (state == adc_cap_pkg::BUS_IDLE) && s_axil_arvalid &&
                      !(s_axil_awvalid && s_axil_wvalid);

  // both write channels are taken in the same cycle
  assign s_axil_awready = write_fire;
  assign s_axil_wready  = write_fire;
  assign s_axil_arready = read_fire;

  // response valids come straight out of the state register
  assign s_axil_bvalid = (state == adc_cap_pkg::BUS_WRESP);
  assign s_axil_rvalid = (state == adc_cap_pkg::BUS_RDATA);

  // every access completes with OKAY
  assign s_axil_bresp = 2'b00;
  assign s_axil_rresp = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= adc_cap_pkg::BUS_IDLE;
    end else begin
      unique case (state)
        adc_cap_pkg::BUS_IDLE: begin
          if (write_fire) begin
            state <= adc_cap_pkg::BUS_WRESP;
          end else if (read_fire) begin
            state <= adc_cap_pkg::BUS_RDATA;
          end
        end
        adc_cap_pkg::BUS_WRESP: begin
          // hold the response until the host takes it
          if (s_axil_bready) begin
            state <= adc_cap_pkg::BUS_IDLE;
          end
        end
        adc_cap_pkg::BUS_RDATA: begin
          if (s_axil_rready) begin
            state <= adc_cap_pkg::BUS_IDLE;
          end
        end
        default: begin
          state <= adc_cap_pkg::BUS_IDLE;
        end
      endcase
    end
  end

  // ******************************
  // register writes
  // ******************************

  assign status_clr = write_fire && (s_axil_awaddr == adc_cap_pkg::ADDR_STATUS) &&
                      s_axil_wstrb[0] && s_axil_wdata[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      enable    <= 1'b0;
      format    <= 1'b0;
      frame_len <= adc_cap_pkg::FRAME_LEN_RST;
    end else if (write_fire) begin
      // control fields sit in the low byte
      if ((s_axil_awaddr == adc_cap_pkg::ADDR_CTRL) && s_axil_wstrb[0]) begin
        enable <= s_axil_wdata[0];
        format <= s_axil_wdata[1];
      end
      // frame length spans the two low bytes, each under its own strobe
      if (s_axil_awaddr == adc_cap_pkg::ADDR_FRAME_LEN) begin
        if (s_axil_wstrb[0]) begin
          frame_len[7:0] <= s_axil_wdata[7:0];
        end
        if (s_axil_wstrb[1]) begin
          frame_len[15:8] <= s_axil_wdata[15:8];
        end
      end
    end
  end

  // a new overflow in the same cycle as the clear keeps the bit set
  always_ff @(posedge clk) begin
    if (rst) begin
      overflow_sticky <= 1'b0;
    end else if (overflow) begin
      overflow_sticky <= 1'b1;
    end else if (status_clr) begin
      overflow_sticky <= 1'b0;
    end
  end

  // ******************************
  // register reads
  // ******************************

  // undefined addresses read as zero
  always_comb begin
    rd_mux = '0;
    case (s_axil_araddr)
      adc_cap_pkg::ADDR_CTRL:      rd_mux = {30'd0, format, enable};
      adc_cap_pkg::ADDR_FRAME_LEN: rd_mux = {16'd0, frame_len};
      adc_cap_pkg::ADDR_STATUS:    rd_mux = {31'd0, overflow_sticky};
      adc_cap_pkg::ADDR_FRAME_CNT: rd_mux = frame_cnt;
      default:                     rd_mux = '0;
    endcase
  end

  // read data is captured when the address is accepted and held with rvalid
  always_ff @(posedge clk) begin
    if (read_fire) begin
      s_axil_rdata <= rd_mux;
    end
  end

endmodule

/* hw/adc_frame_gen.sv */
// ******************************
// gates raw converter samples with enable, converts the format,
// marks frame boundaries and counts completed frames
// ******************************

module adc_frame_gen #(
  parameter int SAMPLE_WIDTH = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    format,
  input  adc_cap_pkg::frame_len_t frame_len,
  input  logic                    adc_valid,
  input  logic [SAMPLE_WIDTH-1:0] adc_data,
  output logic                    valid,
  output logic                    last,
  output logic [SAMPLE_WIDTH-1:0] data,
  output adc_cap_pkg::frame_cnt_t frame_cnt
);

  adc_cap_pkg::frame_len_t pos;
  adc_cap_pkg::frame_len_t pos_final;
  logic                    take;
  logic                    at_final;

  assign take = enable && adc_valid;

  // the final position wraps to all ones for a length of zero,
  // which gives frames of 65536 samples
  assign pos_final = frame_len - 16'd1;
  assign at_final  = (pos == pos_final);

  // ******************************
  // frame position and count
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      valid     <= 1'b0;
      pos       <= '0;
      frame_cnt <= '0;
    end else begin
      valid <= take;
      if (!enable) begin
        // restart the frame so the next enable begins at position zero
        pos <= '0;
      end else if (adc_valid) begin
        pos <= at_final ? '0 : pos + 16'd1;
        if (at_final) begin
          frame_cnt <= frame_cnt + 32'd1;
        end
      end
    end
  end

  // ******************************
  // sample path
  // ******************************

  // offset binary turns into two's complement by flipping the sign bit
  always_ff @(posedge clk) begin
    if (take) begin
      last <= at_final;
      data <= format ? {~adc_data[SAMPLE_WIDTH-1], adc_data[SAMPLE_WIDTH-2:0]} : adc_data;
    end
  end

endmodule

/* hw/axis_inf_rx.sv */
// ******************************
// receive buffer from a flow without ready to an AXI-Stream master
// with back-pressure, flags samples lost to a full buffer
// ******************************

module axis_inf_rx #(
  parameter int DATA_WIDTH = 16,
  parameter int DEPTH      = 8
) (
  input  logic                  clk,
  input  logic                  rst,

  // flow from the frame generator, no ready
  input  logic                  valid,
  input  logic                  last,
  input  logic [DATA_WIDTH-1:0] data,

  // AXI-Stream master
  output logic                  m_axis_tvalid,
  output logic                  m_axis_tlast,
  output logic [DATA_WIDTH-1:0] m_axis_tdata,
  input  logic                  m_axis_tready,

  // one cycle pulse per dropped sample
  output logic                  overflow
);

  localparam int AW = $clog2(DEPTH);

  // each entry keeps last above the data
  logic [DATA_WIDTH:0] mem [DEPTH];
  logic [AW:0]         wr_ptr;
  logic [AW:0]         rd_ptr;
  logic                empty;
  logic                full;
  logic                wr_en;
  logic                load_en;

  // the extra pointer bit tells a full array from an empty one
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign wr_en = valid && !full;

  // ******************************
  // write side
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // a sample that finds the array full is discarded and reported
      overflow <= valid && full;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= {last, data};
    end
  end

  // ******************************
  // read side
  // ******************************

  // the output register refills when it is empty or its beat is taken
  assign load_en = m_axis_tready || !m_axis_tvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr        <= '0;
      m_axis_tvalid <= 1'b0;
    end else if (load_en) begin
      m_axis_tvalid <= !empty;
      if (!empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // payload only moves with a valid entry, so it holds while stalled
  always_ff @(posedge clk) begin
    if (load_en && !empty) begin
      {m_axis_tlast, m_axis_tdata} <= mem[rd_ptr[AW-1:0]];
    end
  end

endmodule

/* hw/adc_cap_top.sv */
// ******************************
// converter capture subsystem with AXI-Stream output and AXI4-Lite control
// set SAMPLE_WIDTH and BUF_DEPTH here, they are passed down to the datapath
// ******************************

module adc_cap_top #(
  parameter int SAMPLE_WIDTH = 16,
  parameter int BUF_DEPTH    = 8
) (
  input  logic                    clk,
  input  logic                    rst,

  // converter data port
  input  logic                    adc_valid,
  input  logic [SAMPLE_WIDTH-1:0] adc_data,

  // AXI-Stream master
  output logic                    m_axis_tvalid,
  output logic                    m_axis_tlast,
  output logic [SAMPLE_WIDTH-1:0] m_axis_tdata,
  input  logic                    m_axis_tready,

  // AXI4-Lite slave
  input  logic                    s_axil_awvalid,
  output logic                    s_axil_awready,
  input  adc_cap_pkg::reg_addr_t  s_axil_awaddr,
  input  logic                    s_axil_wvalid,
  output logic                    s_axil_wready,
  input  adc_cap_pkg::reg_data_t  s_axil_wdata,
  input  logic [3:0]              s_axil_wstrb,
  output logic                    s_axil_bvalid,
  input  logic                    s_axil_bready,
  output logic [1:0]              s_axil_bresp,
  input  logic                    s_axil_arvalid,
  output logic                    s_axil_arready,
  input  adc_cap_pkg::reg_addr_t  s_axil_araddr,
  output logic                    s_axil_rvalid,
  input  logic                    s_axil_rready,
  output adc_cap_pkg::reg_data_t  s_axil_rdata,
  output logic [1:0]              s_axil_rresp
);

  // control and status between the register block and the datapath
  logic                    enable;
  logic                    format;
  adc_cap_pkg::frame_len_t frame_len;
  adc_cap_pkg::frame_cnt_t frame_cnt;
  logic                    overflow;

  // framed flow into the receive buffer
  logic                    gen_valid;
  logic                    gen_last;
  logic [SAMPLE_WIDTH-1:0] gen_data;

  adc_cap_regs u_regs (
    .clk            (clk),
    .rst            (rst),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .enable         (enable),
    .format         (format),
    .frame_len      (frame_len),
    .frame_cnt      (frame_cnt),
    .overflow       (overflow)
  );

  adc_frame_gen #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) u_frame_gen (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .format    (format),
    .frame_len (frame_len),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .valid     (gen_valid),
    .last      (gen_last),
    .data      (gen_data),
    .frame_cnt (frame_cnt)
  );

  axis_inf_rx #(
    .DATA_WIDTH (SAMPLE_WIDTH),
    .DEPTH      (BUF_DEPTH)
  ) u_rx_buf (
    .clk           (clk),
    .rst           (rst),
    .valid         (gen_valid),
    .last          (gen_last),
    .data          (gen_data),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tready (m_axis_tready),
    .overflow      (overflow)
  );

endmodule

/* dv/adc_cap_asserts.sv */
// ******************************
// handshake rules for the stream and register bus of the capture top level
// attached to every adc_cap_top by the bind at the end of this file
// ******************************

module adc_cap_asserts #(
  parameter int SAMPLE_WIDTH = 16
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    m_axis_tvalid,
  input logic                    m_axis_tready,
  input logic                    m_axis_tlast,
  input logic [SAMPLE_WIDTH-1:0] m_axis_tdata,
  input logic                    s_axil_bvalid,
  input logic                    s_axil_bready,
  input logic                    s_axil_rvalid,
  input logic                    s_axil_rready
);

  // number of assertion failures seen so far, watched by the testbench
  int fail_count = 0;

  // a stalled beat keeps its valid, last and data on the next cycle
  a_stream_hold: assert property (@(posedge clk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tlast) && $stable(m_axis_tdata))
    else begin
      $error("stream beat changed or dropped while tready was low");
      fail_count++;
    end

  // the write response stays up until the host takes it
  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      $error("bvalid fell before bready");
      fail_count++;
    end

  // same rule for read data
  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else begin
      $error("rvalid fell before rready");
      fail_count++;
    end

endmodule

bind adc_cap_top adc_cap_asserts #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_asserts (
  .clk           (clk),
  .rst           (rst),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tdata  (m_axis_tdata),
  .s_axil_bvalid (s_axil_bvalid),
  .s_axil_bready (s_axil_bready),
  .s_axil_rvalid (s_axil_rvalid),
  .s_axil_rready (s_axil_rready)
);

/* dv/adc_cap_tb.sv */
// ******************************
// directed testbench for the capture top level, register bus and stream
// run from the project root with the file list, adc_cap_tb is the top
// ******************************

module adc_cap_tb;

  localparam int SAMPLE_WIDTH = 16;
  localparam int BUF_DEPTH    = 8;
  localparam int RESET_CYCLES = 8;
  // samples over all tests, bus accesses and fixed idle waits set the watchdog
  localparam int SAMPLE_TOTAL = 20 + 20 + 64 + (BUF_DEPTH + 4) + 10;
  localparam int BUS_OPS      = 40;
  localparam int IDLE_WAITS   = 80;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * SAMPLE_TOTAL + 4 * BUS_OPS +
                                  IDLE_WAITS + 1000;
  localparam int WAIT_LIMIT   = 500;

  logic clk;
  logic rst;
  logic adc_valid;
  logic [SAMPLE_WIDTH-1:0] adc_data;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  logic [SAMPLE_WIDTH-1:0] m_axis_tdata;
  logic m_axis_tready;
  logic s_axil_awvalid;
  logic s_axil_awready;
  adc_cap_pkg::reg_addr_t s_axil_awaddr;
  logic s_axil_wvalid;
  logic s_axil_wready;
  adc_cap_pkg::reg_data_t s_axil_wdata;
  logic [3:0] s_axil_wstrb;
  logic s_axil_bvalid;
  logic s_axil_bready;
  logic [1:0] s_axil_bresp;
  logic s_axil_arvalid;
  logic s_axil_arready;
  adc_cap_pkg::reg_addr_t s_axil_araddr;
  logic s_axil_rvalid;
  logic s_axil_rready;
  adc_cap_pkg::reg_data_t s_axil_rdata;
  logic [1:0] s_axil_rresp;

  // samples driven in order, and beats seen as {last, data}
  logic [SAMPLE_WIDTH-1:0] sent[$];
  logic [SAMPLE_WIDTH:0]   beats[$];
  // tready is either a fixed level or a prepared random pattern
  bit ready_mode;
  bit ready_level;
  bit ready_pat[256];
  int ready_idx;
  int frames_exp;
  adc_cap_pkg::reg_data_t rd;

  adc_cap_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ******************************
  // failure reporting and checks
  // ******************************

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h",
                          $time, what, got, exp));
    end
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run("watchdog expired, the tests did not finish in time");
  end

  // the bound assertions count their failures, stop at the first one
  always @(negedge clk) begin
    if (dut.u_asserts.fail_count != 0) begin
      abort_run("a handshake assertion on the DUT failed");
    end
  end

  // ******************************
  // stream side
  // ******************************

  // outputs are steady at the falling edge and transfer on the next rising one
  always @(negedge clk) begin
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      beats.push_back({m_axis_tlast, m_axis_tdata});
    end
  end

  always @(posedge clk) begin
    if (ready_mode) begin
      m_axis_tready <= ready_pat[ready_idx % 256];
      ready_idx <= ready_idx + 1;
    end else begin
      m_axis_tready <= ready_level;
    end
  end

  // mode changes at the falling edge so the driver sees them cleanly
  task automatic set_ready(input bit mode, input bit level);
    @(negedge clk);
    ready_mode = mode;
    ready_level = level;
  endtask

  // with throttle set, at most BUF_DEPTH samples are in flight at once
  task automatic send_samples(input int n, input bit throttle);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd = $urandom;
      @(posedge clk);
      while (throttle && (sent.size() - beats.size() >= BUF_DEPTH)) begin
        adc_valid <= 1'b0;
        @(posedge clk);
      end
      adc_valid <= 1'b1;
      adc_data  <= rnd[SAMPLE_WIDTH-1:0];
      sent.push_back(rnd[SAMPLE_WIDTH-1:0]);
    end
    @(posedge clk);
    adc_valid <= 1'b0;
  endtask

  task automatic wait_beats(input int n);
    int cycles;
    cycles = 0;
    while (beats.size() < n) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("stream beats did not arrive in time");
      end
    end
  endtask

  // offset binary flips the MSB, every len-th beat carries last
  task automatic check_stream(input bit fmt, input int len);
    logic [SAMPLE_WIDTH-1:0] exp_data;
    wait_beats(sent.size());
    check_eq(beats.size(), sent.size(), "beat count");
    for (int k = 0; k < sent.size(); k++) begin
      exp_data = sent[k];
      if (fmt) begin
        exp_data[SAMPLE_WIDTH-1] = ~exp_data[SAMPLE_WIDTH-1];
      end
      check_eq(beats[k][SAMPLE_WIDTH-1:0], exp_data, $sformatf("tdata of beat %0d", k));
      check_eq(beats[k][SAMPLE_WIDTH], ((k + 1) % len) == 0, $sformatf("tlast of beat %0d", k));
    end
    sent.delete();
    beats.delete();
  endtask

  // ******************************
  // register bus
  // ******************************

  task automatic axil_write(input adc_cap_pkg::reg_addr_t addr, input adc_cap_pkg::reg_data_t data);
    int cycles;
    @(posedge clk);
    s_axil_awvalid <= 1'b1;
    s_axil_awaddr  <= addr;
    s_axil_wvalid  <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= 4'hf;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("register write was never accepted");
    end while (!s_axil_awready);
    // address and data are taken together on the same cycle
    check_eq(s_axil_wready, 1'b1, "wready with awready");
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("register write got no response");
    end while (!s_axil_bvalid);
    // the response is taken one cycle late, so it has to wait for bready
    s_axil_bready <= 1'b1;
    @(posedge clk);
    check_eq(s_axil_bvalid, 1'b1, "bvalid held until bready");
    check_eq(s_axil_bresp, 2'b00, "write response");
    s_axil_bready <= 1'b0;
  endtask

  task automatic axil_read(input adc_cap_pkg::reg_addr_t addr, output adc_cap_pkg::reg_data_t data);
    int cycles;
    @(posedge clk);
    s_axil_arvalid <= 1'b1;
    s_axil_araddr  <= addr;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("register read was never accepted");
    end while (!s_axil_arready);
    s_axil_arvalid <= 1'b0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("register read returned no data");
    end while (!s_axil_rvalid);
    // read data waits one cycle for rready
    s_axil_rready <= 1'b1;
    @(posedge clk);
    check_eq(s_axil_rvalid, 1'b1, "rvalid held until rready");
    check_eq(s_axil_rresp, 2'b00, "read response");
    data = s_axil_rdata;
    s_axil_rready <= 1'b0;
  endtask

  // a pass through enable low restarts the frame position
  task automatic start_capture(input bit fmt);
    axil_write(adc_cap_pkg::ADDR_CTRL, 32'd0);
    axil_write(adc_cap_pkg::ADDR_CTRL, {30'd0, fmt, 1'b1});
  endtask

  task automatic check_frame_cnt(input string what);
    adc_cap_pkg::reg_data_t val;
    axil_read(adc_cap_pkg::ADDR_FRAME_CNT, val);
    check_eq(val, frames_exp, what);
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_registers();
    axil_read(adc_cap_pkg::ADDR_CTRL, rd);
    check_eq(rd, 32'd0, "control after reset");
    axil_read(adc_cap_pkg::ADDR_FRAME_LEN, rd);
    check_eq(rd, 32'd16, "frame length after reset");
    axil_read(adc_cap_pkg::ADDR_STATUS, rd);
    check_eq(rd, 32'd0, "status after reset");
    check_frame_cnt("frame count after reset");
    axil_write(adc_cap_pkg::ADDR_CTRL, 32'h0000_0002);
    axil_read(adc_cap_pkg::ADDR_CTRL, rd);
    check_eq(rd, 32'h0000_0002, "control readback");
    axil_write(adc_cap_pkg::ADDR_FRAME_LEN, 32'd5);
    axil_read(adc_cap_pkg::ADDR_FRAME_LEN, rd);
    check_eq(rd, 32'd5, "frame length readback");
    axil_read(4'h3, rd);
    check_eq(rd, 32'd0, "undefined address");
    axil_write(adc_cap_pkg::ADDR_CTRL, 32'd0);
  endtask

  task automatic test_stream(input bit fmt);
    start_capture(fmt);
    send_samples(20, 1'b0);
    check_stream(fmt, 5);
    frames_exp += 4;
    check_frame_cnt("frame count after 20 samples");
  endtask

  task automatic test_backpressure();
    start_capture(1'b0);
    set_ready(1'b1, 1'b1);
    send_samples(64, 1'b1);
    check_stream(1'b0, 5);
    set_ready(1'b0, 1'b1);
    frames_exp += 64 / 5;
    axil_read(adc_cap_pkg::ADDR_STATUS, rd);
    check_eq(rd, 32'd0, "status after throttled stream");
  endtask

  task automatic test_overflow();
    start_capture(1'b0);
    set_ready(1'b0, 1'b0);
    send_samples(BUF_DEPTH + 4, 1'b0);
    repeat (4) @(posedge clk);
    axil_read(adc_cap_pkg::ADDR_STATUS, rd);
    check_eq(rd, 32'd1, "status after overflow");
    set_ready(1'b0, 1'b1);
    wait_beats(BUF_DEPTH + 1);
    repeat (20) @(posedge clk);
    check_eq(beats.size(), BUF_DEPTH + 1, "beats kept through overflow");
    // the samples that found the buffer full are gone
    repeat (3) void'(sent.pop_back());
    check_stream(1'b0, 5);
    frames_exp += (BUF_DEPTH + 4) / 5;
    check_frame_cnt("frame count after overflow");
    axil_write(adc_cap_pkg::ADDR_STATUS, 32'd1);
    axil_read(adc_cap_pkg::ADDR_STATUS, rd);
    check_eq(rd, 32'd0, "status after clear");
  endtask

  task automatic test_disabled();
    axil_write(adc_cap_pkg::ADDR_CTRL, 32'd0);
    send_samples(10, 1'b0);
    repeat (20) @(posedge clk);
    check_eq(beats.size(), 0, "beats while disabled");
    sent.delete();
    check_frame_cnt("frame count while disabled");
  endtask

  initial begin
    logic [31:0] rnd;
    void'($urandom(32'hbf3d_eaa7));
    for (int i = 0; i < 256; i++) begin
      rnd = $urandom;
      ready_pat[i] = rnd[0];
    end
    rst = 1'b1;
    adc_valid = 1'b0;
    adc_data = '0;
    m_axis_tready = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_awaddr = '0;
    s_axil_wvalid = 1'b0;
    s_axil_wdata = '0;
    s_axil_wstrb = 4'h0;
    s_axil_bready = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_araddr = '0;
    s_axil_rready = 1'b0;
    ready_mode = 1'b0;
    ready_level = 1'b1;
    ready_idx = 0;
    frames_exp = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    test_stream(1'b0);
    test_stream(1'b1);
    test_backpressure();
    test_overflow();
    test_disabled();
    if (dut.u_asserts.fail_count != 0) begin
      abort_run("a handshake assertion on the DUT failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* vlog.f */
hw/adc_cap_pkg.sv
hw/adc_cap_regs.sv
hw/adc_frame_gen.sv
hw/axis_inf_rx.sv
hw/adc_cap_top.sv
dv/adc_cap_asserts.sv
dv/adc_cap_tb.sv
